// File: build.f
design/tlb_pkg.sv
design/tlb_match_if.sv
design/tlb_write_if.sv
design/plru_tree.sv
design/tlb_req_front.sv
design/tlb_match_stage.sv
design/tlb_update_stage.sv
design/tlb_top.sv
verif/tlb_tb.sv

// File: design/plru_tree.sv
// pseudo-LRU tree: records used entries and names the least recently used one for replacement
`timescale 1ns/100ps
`default_nettype none

module plru_tree #(
    parameter int unsigned ENTRIES = 8
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // entry used this cycle, one-hot or zero
    input  logic [ENTRIES-1:0] used_i,
    // least recently used entry, one-hot
    output logic [ENTRIES-1:0] plru_o
);

    // node layout, heap order
    //   level 0:        0
    //   level 1:     1     2
    //   level 2:    3 4   5 6
    // a node bit of 1 points to the upper half below it
    logic [ENTRIES-2:0] tree_q;
    logic [ENTRIES-2:0] tree_d;

    // node on the path of entry idx at level lvl
    function automatic int unsigned node_of(int unsigned idx, int unsigned lvl);
        return ((2 ** lvl) - 1) + (idx >> ($clog2(ENTRIES) - lvl));
    endfunction

    // branch entry idx takes below its node at level lvl
    function automatic logic branch_of(int unsigned idx, int unsigned lvl);
        return 1'((idx >> ($clog2(ENTRIES) - lvl - 1)) & 1);
    endfunction

    // point every node on the used entry's path away from it
    always_comb begin
        tree_d = tree_q;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            if (used_i[i]) begin
                for (int unsigned lvl = 0; lvl < $clog2(ENTRIES); lvl++) begin
                    tree_d[node_of(i, lvl)] = ~branch_of(i, lvl);
                end
            end
        end
    end

    // victim is the only entry whose whole path agrees with the node bits
    always_comb begin
        plru_o = '1;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            for (int unsigned lvl = 0; lvl < $clog2(ENTRIES); lvl++) begin
                if (branch_of(i, lvl)) begin
                    plru_o[i] &= tree_q[node_of(i, lvl)];
                end else begin
                    plru_o[i] &= ~tree_q[node_of(i, lvl)];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

    // the tree indexing only works for a full binary tree
    assert property (@(posedge clk_i) ENTRIES == 2 ** $clog2(ENTRIES))
        else $error("ENTRIES must be a power of two");

    // an entry that was just used is never the next victim
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (used_i != '0) |=> ((plru_o & $past(used_i)) == '0))
        else $error("victim vector names the entry used in the previous cycle");

endmodule

`default_nettype wire

// File: design/tlb_match_if.sv
// match result bundle, driven by the match stage and consumed by the update stage
`timescale 1ns/100ps
`default_nettype none

interface tlb_match_if;

    // single-cycle pulse, one per request
    logic                      valid;
    // operation of the request
    tlb_pkg::tlb_op_e          op;
    // virtual page number of the request
    logic [tlb_pkg::VPN_W-1:0] vpn;
    // fill: requested ppn
    // lookup: ppn of the matching entry, zero on a miss
    logic [tlb_pkg::PPN_W-1:0] ppn;
    // one-hot or zero compare result
    tlb_pkg::entry_vec_t       hit_vec;
    // valid bits at compare time
    tlb_pkg::entry_vec_t       valid_vec;

    // producer side
    modport match_mp (
        output valid, op, vpn, ppn, hit_vec, valid_vec
    );

    // consumer side
    modport update_mp (
        input valid, op, vpn, ppn, hit_vec, valid_vec
    );

endinterface

`default_nettype wire

// File: design/tlb_match_stage.sv
// entry storage and registered fully associative compare of a request against all entries
`timescale 1ns/100ps
`default_nettype none

module tlb_match_stage (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      launch_i,
    input  tlb_pkg::tlb_op_e          op_i,
    input  logic [tlb_pkg::VPN_W-1:0] vpn_i,
    input  logic [tlb_pkg::PPN_W-1:0] ppn_i,
    tlb_match_if.match_mp             m,
    tlb_write_if.store_mp             w
);

    tlb_pkg::entry_vec_t       valid_q;
    logic [tlb_pkg::VPN_W-1:0] vpn_q [tlb_pkg::ENTRIES];
    logic [tlb_pkg::PPN_W-1:0] ppn_q [tlb_pkg::ENTRIES];
    tlb_pkg::entry_vec_t       hit_d;
    logic [tlb_pkg::PPN_W-1:0] hit_ppn;

    // compare against every valid entry in parallel
    always_comb begin
        hit_d   = '0;
        hit_ppn = '0;
        for (int unsigned i = 0; i < tlb_pkg::ENTRIES; i++) begin
            hit_d[i] = valid_q[i] && (vpn_q[i] == vpn_i);
            // at most one hit, so or-ing selects its ppn
            if (hit_d[i]) begin
                hit_ppn |= ppn_q[i];
            end
        end
    end

    // valid bits, flush wins over a write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (w.flush) begin
            valid_q <= '0;
        end else if (w.we) begin
            valid_q[w.idx] <= 1'b1;
        end
    end

    // page numbers of the entries
    always_ff @(posedge clk_i) begin
        if (w.we) begin
            vpn_q[w.idx] <= w.vpn;
            ppn_q[w.idx] <= w.ppn;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            m.valid <= 1'b0;
        end else begin
            m.valid <= launch_i;
        end
    end

    // request and compare result move on together
    always_ff @(posedge clk_i) begin
        if (launch_i) begin
            m.op        <= op_i;
            m.vpn       <= vpn_i;
            // a fill carries its new ppn, a lookup the stored one
            m.ppn       <= (op_i == tlb_pkg::OP_FILL) ? ppn_i : hit_ppn;
            m.hit_vec   <= hit_d;
            m.valid_vec <= valid_q;
        end
    end

    // fills reuse a matching entry, so no vpn is ever stored twice
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        m.valid |-> $onehot0(m.hit_vec))
        else $error("more than one entry matched a vpn");

endmodule

`default_nettype wire

// File: design/tlb_pkg.sv
// shared sizes, operation codes and index types for the translation buffer RTL and its testbench
`default_nettype none

package tlb_pkg;

    // number of translation entries, a power of two
    localparam int unsigned ENTRIES = 8;
    // bits of an entry index
    localparam int unsigned LOG_ENTRIES = $clog2(ENTRIES);

    // page number widths
    localparam int unsigned VPN_W = 20;
    localparam int unsigned PPN_W = 16;

    // operations accepted at the request port
    typedef enum logic [1:0] {
        // search by virtual page number
        OP_LOOKUP = 2'd0,
        // write a translation, reusing a matching entry if present
        OP_FILL   = 2'd1,
        // invalidate every entry
        OP_FLUSH  = 2'd2
    } tlb_op_e;

    // index of one entry
    typedef logic [LOG_ENTRIES-1:0] entry_idx_t;

    // one bit per entry: hit vectors, valid bits, tree used/victim vectors
    typedef logic [ENTRIES-1:0] entry_vec_t;

endpackage

`default_nettype wire

// File: design/tlb_req_front.sv
// four-phase req/ack front end: launches one pipeline operation per request and holds its result
`timescale 1ns/100ps
`default_nettype none

module tlb_req_front (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // requester side
    input  logic                      req_i,
    input  tlb_pkg::tlb_op_e          op_i,
    input  logic [tlb_pkg::VPN_W-1:0] vpn_i,
    input  logic [tlb_pkg::PPN_W-1:0] ppn_i,
    // towards the match stage
    output logic                      launch_o,
    output tlb_pkg::tlb_op_e          op_o,
    output logic [tlb_pkg::VPN_W-1:0] vpn_o,
    output logic [tlb_pkg::PPN_W-1:0] ppn_o,
    // results from the update stage
    input  logic                      done_i,
    input  logic                      hit_i,
    input  logic [tlb_pkg::PPN_W-1:0] ppn_res_i,
    input  tlb_pkg::entry_idx_t       idx_i,
    // back to the requester
    output logic                      ack_o,
    output logic                      hit_o,
    output logic [tlb_pkg::PPN_W-1:0] ppn_o_res,
    output tlb_pkg::entry_idx_t       idx_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACKED
    } front_state_e;

    front_state_e state_q;
    // registered copy of req_i, every decision below is taken on it
    logic         req_q;
    logic         start;

    // new request seen while nothing is in flight
    assign start = (state_q == ST_IDLE) && req_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q    <= 1'b0;
            state_q  <= ST_IDLE;
            launch_o <= 1'b0;
            ack_o    <= 1'b0;
        end else begin
            req_q    <= req_i;
            // exactly one launch per request
            launch_o <= start;
            // ack follows the acked state and drops one cycle after req goes low
            ack_o    <= (state_q == ST_ACKED) && req_q;
            case (state_q)
                ST_IDLE: begin
                    if (req_q) begin
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (done_i) begin
                        state_q <= ST_ACKED;
                    end
                end
                ST_ACKED: begin
                    // handshake closes once the requester lets go
                    if (!req_q) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // request payload, stable while req_i is high
    always_ff @(posedge clk_i) begin
        if (start) begin
            op_o  <= op_i;
            vpn_o <= vpn_i;
            ppn_o <= ppn_i;
        end
    end

    // result payload, held until the next request completes
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_BUSY) && done_i) begin
            hit_o     <= hit_i;
            ppn_o_res <= ppn_res_i;
            idx_o     <= idx_i;
        end
    end

    // with req low at one edge, ack must stay low at the next
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!ack_o && !req_i) |=> !ack_o)
        else $error("ack_o rose while req_i was low");

endmodule

`default_nettype wire

// File: design/tlb_top.sv
// translation buffer top level: wires the request front, match stage and update stage together
`timescale 1ns/100ps
`default_nettype none

module tlb_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      req_i,
    input  tlb_pkg::tlb_op_e          op_i,
    input  logic [tlb_pkg::VPN_W-1:0] vpn_i,
    input  logic [tlb_pkg::PPN_W-1:0] ppn_i,
    output logic                      ack_o,
    output logic                      hit_o,
    output logic [tlb_pkg::PPN_W-1:0] ppn_o,
    output tlb_pkg::entry_idx_t       idx_o
);

    // front to match stage
    logic                      launch;
    tlb_pkg::tlb_op_e          op;
    logic [tlb_pkg::VPN_W-1:0] vpn;
    logic [tlb_pkg::PPN_W-1:0] ppn;

    // update stage back to front
    logic                      done;
    logic                      hit;
    logic [tlb_pkg::PPN_W-1:0] ppn_res;
    tlb_pkg::entry_idx_t       idx;

    tlb_match_if i_match_if ();
    tlb_write_if i_write_if ();

    tlb_req_front i_req_front (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (req_i),
        .op_i      (op_i),
        .vpn_i     (vpn_i),
        .ppn_i     (ppn_i),
        .launch_o  (launch),
        .op_o      (op),
        .vpn_o     (vpn),
        .ppn_o     (ppn),
        .done_i    (done),
        .hit_i     (hit),
        .ppn_res_i (ppn_res),
        .idx_i     (idx),
        .ack_o     (ack_o),
        .hit_o     (hit_o),
        .ppn_o_res (ppn_o),
        .idx_o     (idx_o)
    );

    tlb_match_stage i_match_stage (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .launch_i (launch),
        .op_i     (op),
        .vpn_i    (vpn),
        .ppn_i    (ppn),
        .m        (i_match_if.match_mp),
        .w        (i_write_if.store_mp)
    );

    tlb_update_stage i_update_stage (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .m      (i_match_if.update_mp),
        .w      (i_write_if.update_mp),
        .done_o (done),
        .hit_o  (hit),
        .ppn_o  (ppn_res),
        .idx_o  (idx)
    );

endmodule

`default_nettype wire

// File: design/tlb_update_stage.sv
// update stage: picks the fill target, writes entries, updates the replacement tree, returns results
`timescale 1ns/100ps
`default_nettype none

module tlb_update_stage (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    tlb_match_if.update_mp            m,
    tlb_write_if.update_mp            w,
    output logic                      done_o,
    output logic                      hit_o,
    output logic [tlb_pkg::PPN_W-1:0] ppn_o,
    output tlb_pkg::entry_idx_t       idx_o
);

    logic                hit_any;
    logic                any_free;
    tlb_pkg::entry_idx_t hit_idx;
    tlb_pkg::entry_idx_t free_idx;
    tlb_pkg::entry_idx_t victim_idx;
    tlb_pkg::entry_idx_t target;
    tlb_pkg::entry_vec_t used;
    tlb_pkg::entry_vec_t victim_vec;

    assign hit_any  = |m.hit_vec;
    assign any_free = ~&m.valid_vec;

    // encode hit vector, victim vector and lowest invalid entry
    always_comb begin
        hit_idx    = '0;
        victim_idx = '0;
        free_idx   = '0;
        for (int unsigned i = 0; i < tlb_pkg::ENTRIES; i++) begin
            if (m.hit_vec[i]) begin
                hit_idx = tlb_pkg::entry_idx_t'(i);
            end
            if (victim_vec[i]) begin
                victim_idx = tlb_pkg::entry_idx_t'(i);
            end
        end
        // walk downwards so the lowest invalid entry wins
        for (int i = tlb_pkg::ENTRIES - 1; i >= 0; i--) begin
            if (!m.valid_vec[i]) begin
                free_idx = tlb_pkg::entry_idx_t'(i);
            end
        end
    end

    // matching entry first, then a free one, then the tree's victim
    assign target = hit_any ? hit_idx : (any_free ? free_idx : victim_idx);

    // lookup hits and all fills touch the tree
    assign used = (m.valid && ((m.op == tlb_pkg::OP_FILL) ||
                               ((m.op == tlb_pkg::OP_LOOKUP) && hit_any)))
                  ? (tlb_pkg::entry_vec_t'(1) << target) : '0;

    plru_tree #(
        .ENTRIES (tlb_pkg::ENTRIES)
    ) i_plru_tree (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .used_i (used),
        .plru_o (victim_vec)
    );

    // entry write and flush take effect at the next edge
    assign w.we    = m.valid && (m.op == tlb_pkg::OP_FILL);
    assign w.idx   = target;
    assign w.vpn   = m.vpn;
    assign w.ppn   = m.ppn;
    assign w.flush = m.valid && (m.op == tlb_pkg::OP_FLUSH);

    // result is ready in the same cycle as the match
    assign done_o = m.valid;

    always_comb begin
        hit_o = 1'b0;
        ppn_o = '0;
        idx_o = '0;
        case (m.op)
            tlb_pkg::OP_LOOKUP: begin
                hit_o = hit_any;
                // m.ppn already zero on a miss
                ppn_o = m.ppn;
                idx_o = hit_any ? hit_idx : '0;
            end
            tlb_pkg::OP_FILL: begin
                // hit tells the requester the vpn was already present
                hit_o = hit_any;
                ppn_o = m.ppn;
                idx_o = target;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/tlb_write_if.sv
// entry write and flush requests sent from the update stage back to the entry storage
`timescale 1ns/100ps
`default_nettype none

interface tlb_write_if;

    // write one entry at the next clock edge
    logic                      we;
    tlb_pkg::entry_idx_t       idx;
    logic [tlb_pkg::VPN_W-1:0] vpn;
    logic [tlb_pkg::PPN_W-1:0] ppn;
    // clear all valid bits at the next clock edge
    logic                      flush;

    // update stage drives
    modport update_mp (
        output we, idx, vpn, ppn, flush
    );

    // entry storage applies
    modport store_mp (
        input we, idx, vpn, ppn, flush
    );

endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tlb_tb -o tlb_sim -f build.f

status=0
./obj_dir/tlb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
exit 0

// File: verif/tlb_tb.sv
// directed testbench for tlb_top; drives four-phase requests and checks them against a reference model
`timescale 1ns/100ps
`default_nettype none

module tlb_tb;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      req_i;
    tlb_pkg::tlb_op_e          op_i;
    logic [tlb_pkg::VPN_W-1:0] vpn_i;
    logic [tlb_pkg::PPN_W-1:0] ppn_i;
    logic                      ack_o;
    logic                      hit_o;
    logic [tlb_pkg::PPN_W-1:0] ppn_o;
    tlb_pkg::entry_idx_t       idx_o;

    int unsigned errors;
    int unsigned checks;
    logic [31:0] lcg_state;

    // reference model of the entries and the replacement tree
    logic                        model_valid [tlb_pkg::ENTRIES];
    logic [tlb_pkg::VPN_W-1:0]   model_vpn   [tlb_pkg::ENTRIES];
    logic [tlb_pkg::PPN_W-1:0]   model_ppn   [tlb_pkg::ENTRIES];
    logic [tlb_pkg::ENTRIES-2:0] model_tree;

    tlb_top i_dut (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .req_i  (req_i),
        .op_i   (op_i),
        .vpn_i  (vpn_i),
        .ppn_i  (ppn_i),
        .ack_o  (ack_o),
        .hit_o  (hit_o),
        .ppn_o  (ppn_o),
        .idx_o  (idx_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits of the lcg are the least regular
    function automatic logic [tlb_pkg::PPN_W-1:0] rand_ppn();
        logic [31:0] r;
        r = next_rand();
        return r[31 -: tlb_pkg::PPN_W];
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("ERROR %s: hit expected %0b, actual %0b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_ppn(input string name, input logic [tlb_pkg::PPN_W-1:0] exp,
                             input logic [tlb_pkg::PPN_W-1:0] act);
        checks++;
        if (act !== exp) begin
            $display("ERROR %s: ppn expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_idx(input string name, input tlb_pkg::entry_idx_t exp,
                             input tlb_pkg::entry_idx_t act);
        checks++;
        if (act !== exp) begin
            $display("ERROR %s: idx expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // valid entry holding vpn, and lowest invalid entry
    task automatic model_search(input logic [tlb_pkg::VPN_W-1:0] vpn, output logic found,
                                output tlb_pkg::entry_idx_t hit_idx, output logic any_free,
                                output tlb_pkg::entry_idx_t free_idx);
        found    = 1'b0;
        hit_idx  = '0;
        any_free = 1'b0;
        free_idx = '0;
        for (int i = tlb_pkg::ENTRIES - 1; i >= 0; i--) begin
            if (model_valid[i] && (model_vpn[i] == vpn)) begin
                found   = 1'b1;
                hit_idx = tlb_pkg::entry_idx_t'(i);
            end
            if (!model_valid[i]) begin
                any_free = 1'b1;
                free_idx = tlb_pkg::entry_idx_t'(i);
            end
        end
    endtask

    // walk from the root, each node bit picks the half it points to (1 = upper)
    function automatic tlb_pkg::entry_idx_t model_victim();
        int unsigned node;
        int unsigned idx;
        int unsigned b;
        node = 0;
        idx  = 0;
        for (int lvl = 0; lvl < tlb_pkg::LOG_ENTRIES; lvl++) begin
            b    = model_tree[node] ? 1 : 0;
            idx  = idx * 2 + b;
            node = node * 2 + 1 + b;
        end
        return tlb_pkg::entry_idx_t'(idx);
    endfunction

    // nodes on the used entry's path point away from it
    function automatic void model_touch(tlb_pkg::entry_idx_t idx);
        int unsigned node;
        int unsigned b;
        node = 0;
        for (int lvl = tlb_pkg::LOG_ENTRIES - 1; lvl >= 0; lvl--) begin
            b                = (int'(idx) >> lvl) & 1;
            model_tree[node] = (b == 0);
            node             = node * 2 + 1 + b;
        end
    endfunction

    // poll after each edge until ack_o reaches level
    task automatic wait_ack(input logic level);
        int unsigned n;
        n = 0;
        while ((ack_o !== level) && (n < 50)) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (ack_o !== level) begin
            $display("timeout: ack_o did not go to %0b within 50 cycles", level);
            errors++;
        end
    endtask

    // one full four-phase transaction, entered and left 1 ns after a rising edge
    task automatic do_request(input tlb_pkg::tlb_op_e op, input logic [tlb_pkg::VPN_W-1:0] vpn,
                              input logic [tlb_pkg::PPN_W-1:0] ppn, output logic hit,
                              output logic [tlb_pkg::PPN_W-1:0] ppn_res,
                              output tlb_pkg::entry_idx_t idx);
        op_i  = op;
        vpn_i = vpn;
        ppn_i = ppn;
        req_i = 1'b1;
        wait_ack(1'b1);
        hit     = hit_o;
        ppn_res = ppn_o;
        idx     = idx_o;
        req_i   = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic run_lookup(input string name, input logic [tlb_pkg::VPN_W-1:0] vpn,
                              output logic hit);
        logic [tlb_pkg::PPN_W-1:0] ppn;
        tlb_pkg::entry_idx_t       idx;
        logic                      found;
        logic                      any_free;
        tlb_pkg::entry_idx_t       hit_idx;
        tlb_pkg::entry_idx_t       free_idx;
        model_search(vpn, found, hit_idx, any_free, free_idx);
        do_request(tlb_pkg::OP_LOOKUP, vpn, '0, hit, ppn, idx);
        check_bit(name, found, hit);
        if (found) begin
            check_ppn(name, model_ppn[hit_idx], ppn);
            check_idx(name, hit_idx, idx);
            model_touch(hit_idx);
        end else begin
            // miss reports zeros
            check_ppn(name, '0, ppn);
            check_idx(name, '0, idx);
        end
    endtask

    task automatic run_fill(input string name, input logic [tlb_pkg::VPN_W-1:0] vpn,
                            input logic [tlb_pkg::PPN_W-1:0] ppn, output logic hit,
                            output tlb_pkg::entry_idx_t idx);
        logic [tlb_pkg::PPN_W-1:0] ppn_got;
        logic                      found;
        logic                      any_free;
        tlb_pkg::entry_idx_t       hit_idx;
        tlb_pkg::entry_idx_t       free_idx;
        tlb_pkg::entry_idx_t       target;
        model_search(vpn, found, hit_idx, any_free, free_idx);
        // matching entry, else lowest free, else tree victim
        if (found) begin
            target = hit_idx;
        end else if (any_free) begin
            target = free_idx;
        end else begin
            target = model_victim();
        end
        do_request(tlb_pkg::OP_FILL, vpn, ppn, hit, ppn_got, idx);
        check_bit(name, found, hit);
        check_ppn(name, ppn, ppn_got);
        check_idx(name, target, idx);
        model_valid[target] = 1'b1;
        model_vpn[target]   = vpn;
        model_ppn[target]   = ppn;
        model_touch(target);
    endtask

    task automatic run_flush(input string name);
        logic                      hit;
        logic [tlb_pkg::PPN_W-1:0] ppn;
        tlb_pkg::entry_idx_t       idx;
        do_request(tlb_pkg::OP_FLUSH, '0, '0, hit, ppn, idx);
        check_bit(name, 1'b0, hit);
        // tree is kept across a flush
        for (int i = 0; i < tlb_pkg::ENTRIES; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    task automatic test_cold_miss();
        logic hit;
        for (int i = 0; i < 4; i++) begin
            run_lookup("cold_miss", 20'h10000 + 20'(i * 911), hit);
            check_bit("cold_miss", 1'b0, hit);
        end
    endtask

    task automatic test_fill_free();
        logic                hit;
        tlb_pkg::entry_idx_t idx;
        for (int i = 0; i < tlb_pkg::ENTRIES; i++) begin
            run_fill("fill_free", 20'h40000 + 20'(i * 37), rand_ppn(), hit, idx);
            check_idx("fill_free", tlb_pkg::entry_idx_t'(i), idx);
        end
        for (int i = 0; i < tlb_pkg::ENTRIES; i++) begin
            run_lookup("fill_free", 20'h40000 + 20'(i * 37), hit);
            check_bit("fill_free", 1'b1, hit);
        end
    endtask

    task automatic test_plru_victim();
        int                        order [5] = '{3, 0, 6, 1, 5};
        logic                      hit;
        tlb_pkg::entry_idx_t       idx;
        tlb_pkg::entry_idx_t       victim;
        logic [tlb_pkg::VPN_W-1:0] old_vpn;
        for (int k = 0; k < 5; k++) begin
            run_lookup("plru_victim", model_vpn[order[k]], hit);
        end
        victim  = model_victim();
        old_vpn = model_vpn[victim];
        run_fill("plru_victim", 20'h7beef, rand_ppn(), hit, idx);
        check_idx("plru_victim", victim, idx);
        // evicted translation is gone
        run_lookup("plru_victim", old_vpn, hit);
        check_bit("plru_victim", 1'b0, hit);
    endtask

    task automatic test_refill_same();
        logic                      hit;
        tlb_pkg::entry_idx_t       idx;
        logic [tlb_pkg::VPN_W-1:0] vpn;
        vpn = model_vpn[2];
        run_fill("refill_same", vpn, ~model_ppn[2], hit, idx);
        check_bit("refill_same", 1'b1, hit);
        check_idx("refill_same", tlb_pkg::entry_idx_t'(2), idx);
        run_lookup("refill_same", vpn, hit);
    endtask

    task automatic test_flush();
        logic                      hit;
        tlb_pkg::entry_idx_t       idx;
        logic [tlb_pkg::VPN_W-1:0] old_vpn [tlb_pkg::ENTRIES];
        for (int i = 0; i < tlb_pkg::ENTRIES; i++) begin
            old_vpn[i] = model_vpn[i];
        end
        run_flush("flush");
        for (int i = 0; i < tlb_pkg::ENTRIES; i++) begin
            run_lookup("flush", old_vpn[i], hit);
            check_bit("flush", 1'b0, hit);
        end
        run_fill("flush", 20'h5a5a5, rand_ppn(), hit, idx);
        check_idx("flush", '0, idx);
    endtask

    // small vpn pool so hits, refills and evictions all occur
    task automatic test_random_mix();
        logic                      hit;
        tlb_pkg::entry_idx_t       idx;
        logic [31:0]               r;
        logic [tlb_pkg::VPN_W-1:0] vpn;
        for (int n = 0; n < 200; n++) begin
            r   = next_rand();
            vpn = 20'ha0000 + 20'(r[23:16] % 8'd12);
            if (r[31:28] < 4'd7) begin
                run_lookup("random_mix", vpn, hit);
            end else if (r[31:28] < 4'd15) begin
                run_fill("random_mix", vpn, rand_ppn(), hit, idx);
            end else begin
                run_flush("random_mix");
            end
        end
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        lcg_state  = 32'h9270;
        rst_ni     = 1'b0;
        req_i      = 1'b0;
        op_i       = tlb_pkg::OP_LOOKUP;
        vpn_i      = '0;
        ppn_i      = '0;
        model_tree = '0;
        for (int i = 0; i < tlb_pkg::ENTRIES; i++) begin
            model_valid[i] = 1'b0;
            model_vpn[i]   = '0;
            model_ppn[i]   = '0;
        end
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        test_cold_miss();
        test_fill_free();
        test_plru_victim();
        test_refill_same();
        test_flush();
        test_random_mix();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
